/* src/fetch_pkg.sv */
// ------------------------------
// shared types and opcode constants for the rv32i fetch
// front end, imported by every stage and by the interface
// ------------------------------
package fetch_pkg;

    // one instruction address
    typedef logic [31:0] pc_t;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fields_t;

    // jal and jalr layout
    // imm_hi is the i-immediate, and for jal {rs1, funct3} is j-imm 19:12
    typedef struct packed {
        logic [11:0] imm_hi;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } ji_fields_t;

    // same word, two decodes
    typedef union packed {
        b_fields_t  b;
        ji_fields_t ji;
    } inst_t;

    // one predecoded queue entry
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
        logic  is_branch;
        logic  is_jal;
        logic  is_jalr;
        logic  pred_taken;
        pc_t   pred_target;
    } entry_t;

    // ------------------------------
    // opcodes and branch funct3
    // ------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

/* src/fetch_entry_if.sv */
// ------------------------------
// one fetched entry with a valid/ready handshake,
// between fetch and queue, and between queue and issue
// ------------------------------
`timescale 1ns/1ns

interface fetch_entry_if;
    import fetch_pkg::*;

    // sender side
    logic   valid;
    entry_t entry;

    // receiver side
    logic   ready;

    // entry stays steady while valid is high and ready is low
    modport sender (
        output valid,
        output entry,
        input  ready
    );

    modport receiver (
        input  valid,
        input  entry,
        output ready
    );

endinterface

/* src/branch_predecoder.sv */
// ------------------------------
// static branch predecode, purely combinational
// flags jumps and branches, predicts taken and forms the offset
// ------------------------------
`timescale 1ns/1ns

module branch_predecoder (
    input  fetch_pkg::inst_t inst,
    output logic             is_branch,
    output logic             is_jal,
    output logic             is_jalr,
    output logic             pred_taken,
    output fetch_pkg::pc_t   offset
);
    import fetch_pkg::*;

    logic f3_ok;
    pc_t  imm_b;
    pc_t  imm_i;
    pc_t  imm_j;

    // ------------------------------
    // opcode match
    // ------------------------------

    // reserved funct3 codes 010 and 011 are not branches
    always_comb begin
        case (inst.b.funct3)
            F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                f3_ok = 1'b1;
            end
            default: begin
                f3_ok = 1'b0;
            end
        endcase
    end

    // b view for branches
    assign is_branch = (inst.b.opcode == OPC_BRANCH) && f3_ok;

    // j/i view for jumps
    assign is_jal  = (inst.ji.opcode == OPC_JAL);
    assign is_jalr = (inst.ji.opcode == OPC_JALR);

    // ------------------------------
    // immediates
    // ------------------------------

    // b-imm, bit 0 is always zero
    assign imm_b = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                    inst.b.imm4_1, 1'b0};

    // plain 12 bit i-imm for jalr
    assign imm_i = {{20{inst.ji.imm_hi[11]}}, inst.ji.imm_hi};

    // j-imm is scattered over imm_hi, rs1 and funct3
    assign imm_j = {{12{inst.ji.imm_hi[11]}}, inst.ji.rs1, inst.ji.funct3,
                    inst.ji.imm_hi[0], inst.ji.imm_hi[10:1], 1'b0};

    // offset for the fetch adder
    always_comb begin
        if (is_branch) begin
            offset = imm_b;
        end else if (is_jalr) begin
            offset = imm_i;
        end else begin
            // jal, or don't care when not taken
            offset = imm_j;
        end
    end

    // backward branches taken, jumps always taken
    assign pred_taken = (is_branch && imm_b[31]) || is_jal || is_jalr;

endmodule

/* src/fetch_unit.sv */
// ------------------------------
// pc register and wishbone classic read master
// predecodes each word and picks the next pc
// ------------------------------
`timescale 1ns/1ns

module fetch_unit #(
    parameter fetch_pkg::pc_t RESET_PC    = 32'h8000_0000,
    parameter int             QUEUE_DEPTH = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  fetch_pkg::pc_t flush_pc,
    input  logic           flush_pc_p4,
    input  fetch_pkg::pc_t ra_data,
    output logic           wb_cyc,
    output logic           wb_stb,
    output fetch_pkg::pc_t wb_adr,
    input  logic [31:0]    wb_dat_i,
    input  logic           wb_ack,
    input  logic           credit_return,
    fetch_entry_if.sender  fq
);
    import fetch_pkg::*;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // state
    pc_t              pc_q;
    pc_t              adr_q;
    logic             busy_q;
    logic             drop_q;
    logic [CNT_W-1:0] credit_q;

    // predecode results
    inst_t bus_inst;
    logic  is_branch;
    logic  is_jal;
    logic  is_jalr;
    logic  pred_taken;
    pc_t   offset;

    // next pc path
    pc_t   add_base;
    pc_t   add_inc;
    pc_t   next_pc;
    pc_t   pc_d;
    logic  room;
    logic  start;
    logic  accept;

    // bus data goes straight into predecode
    assign bus_inst = wb_dat_i;

    branch_predecoder u_predecoder (
        .inst       (bus_inst),
        .is_branch  (is_branch),
        .is_jal     (is_jal),
        .is_jalr    (is_jalr),
        .pred_taken (pred_taken),
        .offset     (offset)
    );

    // ------------------------------
    // single next-pc adder
    // ------------------------------
    always_comb begin
        if (flush) begin
            // redirect, optionally skip one word
            add_base = flush_pc;
            add_inc  = flush_pc_p4 ? 32'd4 : 32'd0;
        end else begin
            add_base = is_jalr ? ra_data : pc_q;
            add_inc  = pred_taken ? offset : 32'd4;
        end
    end

    assign next_pc = add_base + add_inc;

    // ------------------------------
    // entry out to the queue
    // ------------------------------

    // a dropped word or one acked under flush never leaves
    assign fq.valid = busy_q & wb_ack & ~drop_q & ~flush;
    assign fq.entry = '{
        pc:          pc_q,
        inst:        bus_inst,
        is_branch:   is_branch,
        is_jal:      is_jal,
        is_jalr:     is_jalr,
        pred_taken:  pred_taken,
        pred_target: next_pc
    };
    assign accept = fq.valid & fq.ready;

    assign pc_d = (flush | accept) ? next_pc : pc_q;

    // ------------------------------
    // request control
    // ------------------------------

    // credits cover queue, issue register and the read in flight
    assign room = flush | (credit_q < CNT_W'(QUEUE_DEPTH));

    // idle bus starts at once, a swallowed ack restarts back to back
    always_comb begin
        if (!busy_q) begin
            start = room;
        end else if (wb_ack) begin
            start = (drop_q | flush) & room;
        end else begin
            start = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q     <= RESET_PC;
            busy_q   <= 1'b0;
            drop_q   <= 1'b0;
            credit_q <= '0;
        end else begin
            pc_q   <= pc_d;
            busy_q <= start | (busy_q & ~wb_ack);
            // remember to swallow the pending ack
            if (busy_q & wb_ack) begin
                drop_q <= 1'b0;
            end else if (busy_q & flush) begin
                drop_q <= 1'b1;
            end
            // flush forgets everything in flight
            if (flush) begin
                credit_q <= CNT_W'(start);
            end else begin
                credit_q <= credit_q + CNT_W'(start) - CNT_W'(credit_return);
            end
        end
    end

    // address held for the whole read
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= pc_d;
        end
    end

    assign wb_cyc = busy_q;
    assign wb_stb = busy_q;
    assign wb_adr = adr_q;

endmodule

/* src/inst_queue.sv */
// ------------------------------
// circular buffer of predecoded entries between fetch and
// issue, no fall-through, emptied by flush
// ------------------------------
`timescale 1ns/1ns

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    fetch_entry_if.receiver wr,
    fetch_entry_if.sender   rd
);
    import fetch_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    entry_t           mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] n;
        if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    // ------------------------------
    // handshakes
    // ------------------------------
    assign wr.ready = (count != CNT_W'(QUEUE_DEPTH));
    assign rd.valid = (count != '0);
    assign rd.entry = mem[rd_ptr];

    assign push = wr.valid & wr.ready;
    assign pop  = rd.valid & rd.ready;

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.entry;
        end
    end

    // ------------------------------
    // pointers and count
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // drop all queued entries
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/issue_stage.sv */
// ------------------------------
// one-entry issue register with ready handshake
// returns a fetch credit for every entry taken at the port
// ------------------------------
`timescale 1ns/1ns

module issue_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    fetch_entry_if.receiver qi,
    input  logic            issue_ready,
    output logic            issue_valid,
    output fetch_pkg::pc_t  issue_pc,
    output logic [31:0]     issue_inst,
    output logic            issue_pred_taken,
    output fetch_pkg::pc_t  issue_pred_target,
    output fetch_pkg::pc_t  issue_link,
    output logic            credit_return
);
    import fetch_pkg::*;

    entry_t held_q;
    logic   valid_q;
    logic   take;
    logic   load;

    // held entry leaves this cycle
    assign take = valid_q & issue_ready;

    // refill when empty or emptying, never during a flush
    assign qi.ready = ~flush & (~valid_q | issue_ready);
    assign load     = qi.valid & qi.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (take) begin
            valid_q <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (load) begin
            held_q <= qi.entry;
        end
    end

    // ------------------------------
    // issue port
    // ------------------------------
    assign issue_valid       = valid_q;
    assign issue_pc          = held_q.pc;
    assign issue_inst        = held_q.inst;
    assign issue_pred_taken  = held_q.pred_taken;
    assign issue_pred_target = held_q.pred_target;

    // return address for jal / jalr
    assign issue_link = held_q.pc + 32'd4;

    // counter in fetch resets on flush, so no credit is owed there
    assign credit_return = take;

endmodule

/* src/fetch_top.sv */
// ------------------------------
// top level of the fetch front end, plain ports only
// wires fetch, queue and issue, sets depth and reset pc
// ------------------------------
`timescale 1ns/1ns

module fetch_top #(
    parameter fetch_pkg::pc_t RESET_PC    = 32'h8000_0000,
    parameter int             QUEUE_DEPTH = 4
) (
    input  logic           clk,
    input  logic           reset,

    // redirect from a later stage
    input  logic           flush,
    input  fetch_pkg::pc_t flush_pc,
    input  logic           flush_pc_p4,
    input  fetch_pkg::pc_t ra_data,

    // wishbone classic read master
    output logic           wb_cyc,
    output logic           wb_stb,
    output fetch_pkg::pc_t wb_adr,
    input  logic [31:0]    wb_dat_i,
    input  logic           wb_ack,

    // issue port
    output logic           issue_valid,
    input  logic           issue_ready,
    output fetch_pkg::pc_t issue_pc,
    output logic [31:0]    issue_inst,
    output logic           issue_pred_taken,
    output fetch_pkg::pc_t issue_pred_target,
    output fetch_pkg::pc_t issue_link
);

    // fetch -> queue, queue -> issue
    fetch_entry_if fq ();
    fetch_entry_if qi ();

    logic credit_return;

    // ------------------------------
    // stages
    // ------------------------------
    fetch_unit #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_unit (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .flush_pc      (flush_pc),
        .flush_pc_p4   (flush_pc_p4),
        .ra_data       (ra_data),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_adr        (wb_adr),
        .wb_dat_i      (wb_dat_i),
        .wb_ack        (wb_ack),
        .credit_return (credit_return),
        .fq            (fq.sender)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .wr    (fq.receiver),
        .rd    (qi.sender)
    );

    issue_stage u_issue_stage (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .qi                (qi.receiver),
        .issue_ready       (issue_ready),
        .issue_valid       (issue_valid),
        .issue_pc          (issue_pc),
        .issue_inst        (issue_inst),
        .issue_pred_taken  (issue_pred_taken),
        .issue_pred_target (issue_pred_target),
        .issue_link        (issue_link),
        .credit_return     (credit_return)
    );

endmodule

/* sim/tb_clock_gen.sv */
// ------------------------------
// testbench clock and reset source
// 20 ns clock, reset held high for the first 8 edges
// ------------------------------
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // release on a rising edge, like every other tb input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* sim/fetch_tb.sv */
// ------------------------------
// testbench for the fetch front end, replays fetch_trace.txt
// wishbone memory model, redirects, random back-pressure, checker
// ------------------------------
`timescale 1ns/1ns

module fetch_tb;
    import fetch_pkg::*;

    localparam pc_t RESET_PC    = 32'h8000_0000;
    localparam int  QUEUE_DEPTH = 4;

    // test ids
    localparam int T_RESET = 0;
    localparam int T_SEQ   = 1;
    localparam int T_BRANCH = 2;
    localparam int T_BP    = 3;
    localparam int T_FLUSH = 4;

    logic        clk;
    logic        reset;
    logic        flush;
    pc_t         flush_pc;
    logic        flush_pc_p4;
    pc_t         ra_data;
    logic        wb_cyc;
    logic        wb_stb;
    pc_t         wb_adr;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic        issue_valid;
    logic        issue_ready;
    pc_t         issue_pc;
    logic [31:0] issue_inst;
    logic        issue_pred_taken;
    pc_t         issue_pred_target;
    pc_t         issue_link;

    // ------------------------------
    // trace layout
    // ------------------------------
    // 00..3f image, 40 image length, 41 ra_data, 42 flush count,
    // 48.. flush triples, 60 record count, 61.. records of 4 words
    logic [31:0] trace [0:255];
    int          image_len;
    int          num_flush;
    int          num_rec;
    int          limit;
    int          cycles;

    // checker and driver state
    int   issued;
    int   fl_idx;
    int   pend_wait;
    int   stall_left;
    int   wait_cnt;
    logic after_flush;
    logic prev_taken;
    int   checks [5];
    int   errs [5];

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(8)) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_top (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .flush_pc          (flush_pc),
        .flush_pc_p4       (flush_pc_p4),
        .ra_data           (ra_data),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_adr            (wb_adr),
        .wb_dat_i          (wb_dat_i),
        .wb_ack            (wb_ack),
        .issue_valid       (issue_valid),
        .issue_ready       (issue_ready),
        .issue_pc          (issue_pc),
        .issue_inst        (issue_inst),
        .issue_pred_taken  (issue_pred_taken),
        .issue_pred_target (issue_pred_target),
        .issue_link        (issue_link)
    );

    function automatic string test_name(input int t);
        case (t)
            T_RESET:  return "reset_start";
            T_SEQ:    return "sequential_fetch";
            T_BRANCH: return "branch_prediction";
            T_BP:     return "backpressure";
            default:  return "flush_redirect";
        endcase
    endfunction

    // image words, anything outside gets an addi built from the address
    function automatic logic [31:0] mem_word(input pc_t adr);
        pc_t idx;
        idx = (adr - RESET_PC) >> 2;
        if (adr >= RESET_PC && idx < pc_t'(image_len)) begin
            return trace[idx[5:0]];
        end
        return {adr[31:7] ^ adr[24:0], 7'b0010011};
    endfunction

    task automatic check_value(input int t, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks[t]++;
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %h actual %h", test_name(t), what, exp, act);
            errs[t]++;
        end
    endtask

    // one issued entry against record r
    task automatic check_record(input int r);
        int          base;
        int          t;
        logic [6:0]  opc;
        base = 8'h61 + 4 * r;
        opc  = trace[base + 1][6:0];
        if (r == 0) begin
            t = T_RESET;
        end else if (after_flush) begin
            t = T_FLUSH;
        end else if (prev_taken || opc == OPC_BRANCH || opc == OPC_JAL || opc == OPC_JALR) begin
            t = T_BRANCH;
        end else begin
            t = T_SEQ;
        end
        if (r == 0) begin
            check_value(t, "first pc", RESET_PC, issue_pc);
        end
        check_value(t, "pc", trace[base], issue_pc);
        check_value(t, "inst", trace[base + 1], issue_inst);
        check_value(t, "pred_taken", trace[base + 2], 32'(issue_pred_taken));
        check_value(t, "pred_target", trace[base + 3], issue_pred_target);
        check_value(t, "link", trace[base] + 32'd4, issue_link);
        prev_taken  = trace[base + 2][0];
        after_flush = 1'b0;
    endtask

    task automatic report();
        int failed;
        failed = 0;
        for (int t = 0; t < 5; t++) begin
            $display("test %s: %0d checks, %0d errors", test_name(t), checks[t], errs[t]);
            if (errs[t] != 0 || checks[t] == 0) begin
                failed++;
            end
        end
        $display("tests run 5, passed %0d, failed %0d", 5 - failed, failed);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial begin
        $readmemh("sim/fetch_trace.txt", trace);
        void'($urandom(66));
        flush       = 1'b0;
        flush_pc    = '0;
        flush_pc_p4 = 1'b0;
        wb_dat_i    = '0;
        wb_ack      = 1'b0;
        issue_ready = 1'b0;
        image_len   = trace[8'h40];
        ra_data     = trace[8'h41];
        num_flush   = trace[8'h42];
        num_rec     = trace[8'h60];
        limit       = 40 * num_rec + 200;
        issued      = 0;
        fl_idx      = 0;
        pend_wait   = 0;
        stall_left  = 0;
        wait_cnt    = 0;
        after_flush = 1'b0;
        prev_taken  = 1'b0;
        for (int t = 0; t < 5; t++) begin
            checks[t] = 0;
            errs[t]   = 0;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: only %0d of %0d entries issued", issued, num_rec);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        cycles = 0;
    end

    // ------------------------------
    // driver, memory model, checker
    // ------------------------------
    always @(posedge clk) begin
        logic pending;
        logic go;
        int   fb;
        if (reset) begin
            checks[T_RESET]++;
            if (wb_cyc || wb_stb) begin
                $display("[FAIL] reset_start wb_cyc or wb_stb went high while reset was held");
                errs[T_RESET]++;
            end
        end else begin
            // issue port transfer
            if (issue_valid && issue_ready) begin
                check_record(issued);
                issued++;
                if (issued == 5 || issued == 11) begin
                    stall_left = 30;
                end
            end

            // redirect: first one waits for a read in flight
            fb      = 8'h48 + 3 * fl_idx;
            pending = (fl_idx < num_flush) && (issued == int'(trace[fb]));
            go      = pending && ((wb_cyc && !wb_ack) || fl_idx > 0 || pend_wait >= 10);
            pend_wait = pending ? pend_wait + 1 : 0;
            flush <= go;
            if (go) begin
                flush_pc    <= trace[fb + 1];
                flush_pc_p4 <= trace[fb + 2][0];
                fl_idx++;
                pend_wait   = 0;
                after_flush = 1'b1;
            end

            // wishbone slave, 0 to 3 wait cycles
            if (wb_ack) begin
                wb_ack   <= 1'b0;
                wait_cnt = $urandom % 4;
            end else if (wb_cyc && wb_stb) begin
                if (go) begin
                    // keep the read outstanding across the flush
                    wait_cnt = 2;
                end else if (wait_cnt == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_i <= mem_word(wb_adr);
                end else begin
                    wait_cnt--;
                end
            end

            // back-pressure, long stretches and random drops
            if (stall_left > 0) begin
                checks[T_BP]++;
                if (stall_left <= 5 && wb_cyc) begin
                    $display("[FAIL] backpressure wb_cyc expected 0 actual 1");
                    errs[T_BP]++;
                end
                stall_left--;
                issue_ready <= 1'b0;
            end else if (pending) begin
                issue_ready <= 1'b0;
            end else begin
                issue_ready <= ($urandom % 4) != 0;
            end
        end

        if (!reset && issued >= num_rec) begin
            report();
        end
    end

endmodule

/* sim/fetch_trace.txt */
// image words 00..15, then 40: image length, ra_data, flush count
// 48: flushes (after issued, target, p4), 60: record count, 61: pc inst taken target
@00
00100093 00200113 00300193 00000463 0100006f 00000013 00000013 00000013
00808067 00000013 00000013 00000013 00500293 00600313 00400213 fe000ae3
00700393 00800413 00900493 00a00513 00b00593 00c00613
@40
00000016 80000030 00000002
@48
00000010 80000040 00000000
00000013 80000048 00000001
@60
00000016
80000000 00100093 00000000 80000004
80000004 00200113 00000000 80000008
80000008 00300193 00000000 8000000c
8000000c 00000463 00000000 80000010
80000010 0100006f 00000001 80000020
80000020 00808067 00000001 80000038
80000038 00400213 00000000 8000003c
8000003c fe000ae3 00000001 80000030
80000030 00500293 00000000 80000034
80000034 00600313 00000000 80000038
80000038 00400213 00000000 8000003c
8000003c fe000ae3 00000001 80000030
80000030 00500293 00000000 80000034
80000034 00600313 00000000 80000038
80000038 00400213 00000000 8000003c
8000003c fe000ae3 00000001 80000030
80000040 00700393 00000000 80000044
80000044 00800413 00000000 80000048
80000048 00900493 00000000 8000004c
8000004c 00a00513 00000000 80000050
80000050 00b00593 00000000 80000054
80000054 00c00613 00000000 80000058

/* sim.f */
src/fetch_pkg.sv
src/fetch_entry_if.sv
src/branch_predecoder.sv
src/fetch_unit.sv
src/inst_queue.sv
src/issue_stage.sv
src/fetch_top.sv
sim/tb_clock_gen.sv
sim/fetch_tb.sv
